// File: design/mem_emu_pkg.sv
// Shared types and constants for the memory emulator
// Array size and answer latency are fixed for every instance
// Addresses are byte addresses; the array is organized in dwords
package mem_emu_pkg;

    // --------------------------------------------------
    // Types
    // --------------------------------------------------
    typedef logic [31:0] addr_t;
    typedef logic [63:0] data_t;
    typedef logic [31:0] ins_t;
    typedef logic [3:0]  tag_t;
    typedef logic [1:0]  size_t;
    typedef logic [7:0]  be_t;
    typedef logic [3:0]  except_code_t;

    // --------------------------------------------------
    // Access sizes
    // --------------------------------------------------
    localparam size_t SZ_BYTE   = 2'd0;
    localparam size_t SZ_HALF   = 2'd1;
    localparam size_t SZ_WORD   = 2'd2;
    localparam size_t SZ_DOUBLE = 2'd3;

    // --------------------------------------------------
    // Memory geometry and latency
    // --------------------------------------------------
    localparam int unsigned MEM_DWORDS = 256;
    localparam int unsigned MEM_BYTES  = MEM_DWORDS * 8;
    // Dword index bits taken from the byte address
    localparam int unsigned MEM_IDX_W  = $clog2(MEM_DWORDS);
    // Enabled stages ahead of the skid register
    localparam int unsigned MEM_LAT_STAGES = 2;

    // --------------------------------------------------
    // Exception causes, RISC-V encoding
    // --------------------------------------------------
    localparam except_code_t E_I_ADDR_MISALIGNED  = 4'd0;
    localparam except_code_t E_I_ACCESS_FAULT     = 4'd1;
    localparam except_code_t E_LD_ADDR_MISALIGNED = 4'd4;
    localparam except_code_t E_LD_ACCESS_FAULT    = 4'd5;
    localparam except_code_t E_ST_ADDR_MISALIGNED = 4'd6;
    localparam except_code_t E_ST_ACCESS_FAULT    = 4'd7;
    // Nothing raised
    localparam except_code_t E_NONE               = 4'd15;

endpackage

// File: design/mem_req_decoder.sv
// Request decode for both ports, purely combinational
// Misalignment wins over an access fault
// Byte enables are zero whenever an exception is raised
module mem_req_decoder (
    input  mem_emu_pkg::addr_t        ins_addr_i,
    input  mem_emu_pkg::addr_t        data_addr_i,
    input  logic                      data_store_i,
    input  mem_emu_pkg::size_t        data_size_i,
    output logic                      ins_except_o,
    output mem_emu_pkg::except_code_t ins_code_o,
    output logic                      data_except_o,
    output mem_emu_pkg::except_code_t data_code_o,
    output mem_emu_pkg::be_t          data_be_o
);

    logic             ins_misal;
    logic             ins_fault;
    logic             data_misal;
    logic             data_fault;
    mem_emu_pkg::be_t size_mask;

    // --------------------------------------------------
    // Instruction fetch, always a word
    // --------------------------------------------------
    assign ins_misal    = ins_addr_i[1:0] != 2'b00;
    assign ins_fault    = ins_addr_i >= mem_emu_pkg::MEM_BYTES;
    assign ins_except_o = ins_misal || ins_fault;

    always_comb begin : p_ins_code
        if (ins_misal) begin
            ins_code_o = mem_emu_pkg::E_I_ADDR_MISALIGNED;
        end else if (ins_fault) begin
            ins_code_o = mem_emu_pkg::E_I_ACCESS_FAULT;
        end else begin
            ins_code_o = mem_emu_pkg::E_NONE;
        end
    end

    // --------------------------------------------------
    // Data access
    // --------------------------------------------------
    // Natural alignment and lane mask per size
    always_comb begin : p_data_size
        case (data_size_i)
            mem_emu_pkg::SZ_BYTE: begin
                data_misal = 1'b0;
                size_mask  = 8'h01;
            end
            mem_emu_pkg::SZ_HALF: begin
                data_misal = data_addr_i[0];
                size_mask  = 8'h03;
            end
            mem_emu_pkg::SZ_WORD: begin
                data_misal = data_addr_i[1:0] != 2'b00;
                size_mask  = 8'h0f;
            end
            default: begin
                data_misal = data_addr_i[2:0] != 3'b000;
                size_mask  = 8'hff;
            end
        endcase
    end

    assign data_fault    = data_addr_i >= mem_emu_pkg::MEM_BYTES;
    assign data_except_o = data_misal || data_fault;

    always_comb begin : p_data_code
        data_code_o = mem_emu_pkg::E_NONE;
        if (data_misal) begin
            data_code_o = data_store_i ? mem_emu_pkg::E_ST_ADDR_MISALIGNED
                                       : mem_emu_pkg::E_LD_ADDR_MISALIGNED;
        end else if (data_fault) begin
            data_code_o = data_store_i ? mem_emu_pkg::E_ST_ACCESS_FAULT
                                       : mem_emu_pkg::E_LD_ACCESS_FAULT;
        end
    end

    // Lanes of the dword touched by the access
    assign data_be_o = data_except_o ? '0 : mem_emu_pkg::be_t'(size_mask << data_addr_i[2:0]);

    // A legal access fits in one dword, one enable per byte
    always_comb begin : p_be_check
        assert (data_except_o || ($countones(data_be_o) == (1 << data_size_i)))
            else $error("byte enables do not match the access size");
    end

endmodule

// File: design/mem_array.sv
// Shared dword array for the instruction and data ports
// Reads are combinational, stores land on the accepting edge
// The array has no reset contents; loads are zero-extended
module mem_array (
    input  logic               clk_i,
    input  mem_emu_pkg::addr_t ins_addr_i,
    input  logic               data_valid_i,
    input  logic               data_ready_i,
    input  mem_emu_pkg::addr_t data_addr_i,
    input  logic               data_store_i,
    input  mem_emu_pkg::size_t data_size_i,
    input  mem_emu_pkg::data_t data_wdata_i,
    input  mem_emu_pkg::be_t   data_be_i,
    output mem_emu_pkg::data_t ins_rdata_o,
    output mem_emu_pkg::data_t data_rdata_o
);

    mem_emu_pkg::data_t             mem [mem_emu_pkg::MEM_DWORDS];
    logic [mem_emu_pkg::MEM_IDX_W-1:0] ins_idx;
    logic [mem_emu_pkg::MEM_IDX_W-1:0] data_idx;
    mem_emu_pkg::data_t             ins_dword;
    mem_emu_pkg::ins_t              ins_word;
    mem_emu_pkg::data_t             data_dword;
    mem_emu_pkg::data_t             data_shift;
    mem_emu_pkg::data_t             wdata_shift;
    mem_emu_pkg::data_t             lane_mask;
    logic                           wr_en;

    // --------------------------------------------------
    // Instruction read
    // --------------------------------------------------
    assign ins_idx     = ins_addr_i[3 +: mem_emu_pkg::MEM_IDX_W];
    assign ins_dword   = mem[ins_idx];
    // Upper or lower half of the dword
    assign ins_word    = ins_addr_i[2] ? ins_dword[63:32] : ins_dword[31:0];
    assign ins_rdata_o = {32'h0, ins_word};

    // --------------------------------------------------
    // Data load
    // --------------------------------------------------
    assign data_idx   = data_addr_i[3 +: mem_emu_pkg::MEM_IDX_W];
    assign data_dword = mem[data_idx];
    assign data_shift = data_dword >> {data_addr_i[2:0], 3'b000};

    always_comb begin : p_load
        case (data_size_i)
            mem_emu_pkg::SZ_BYTE: data_rdata_o = {56'h0, data_shift[7:0]};
            mem_emu_pkg::SZ_HALF: data_rdata_o = {48'h0, data_shift[15:0]};
            mem_emu_pkg::SZ_WORD: data_rdata_o = {32'h0, data_shift[31:0]};
            default:              data_rdata_o = data_shift;
        endcase
        // Stores answer with zero
        if (data_store_i) begin
            data_rdata_o = '0;
        end
    end

    // --------------------------------------------------
    // Masked store
    // --------------------------------------------------
    always_comb begin : p_lane_mask
        for (int b = 0; b < 8; b++) begin
            lane_mask[b*8 +: 8] = {8{data_be_i[b]}};
        end
    end

    assign wr_en       = data_valid_i && data_ready_i && data_store_i;
    assign wdata_shift = data_wdata_i << {data_addr_i[2:0], 3'b000};

    always_ff @(posedge clk_i) begin : p_store
        if (wr_en) begin
            mem[data_idx] <= (data_dword & ~lane_mask) | (wdata_shift & lane_mask);
        end
    end

    // Disabled lanes of the written dword keep their old bytes
    property p_lane_hold;
        @(posedge clk_i) wr_en |=>
            ((mem[$past(data_idx)] & ~$past(lane_mask))
             === ($past(data_dword) & ~$past(lane_mask)));
    endproperty

    a_lane_hold : assert property (p_lane_hold)
        else $error("store modified a disabled byte lane");

endmodule

// File: design/mem_ans_pipe.sv
// Answer path for one port: latency stages, then a two-entry skid
// Answers leave in request order after MEM_LAT_STAGES+1 cycles
// ready_o is low while the spare entry is full or a flush is applied
module mem_ans_pipe (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      flush_i,
    input  logic                      valid_i,
    input  logic                      ready_i,
    input  mem_emu_pkg::tag_t         tag_i,
    input  mem_emu_pkg::data_t        value_i,
    input  logic                      except_i,
    input  mem_emu_pkg::except_code_t code_i,
    output logic                      valid_o,
    output logic                      ready_o,
    output mem_emu_pkg::tag_t         tag_o,
    output mem_emu_pkg::data_t        value_o,
    output logic                      except_o,
    output mem_emu_pkg::except_code_t code_o
);

    // Latency stages
    logic                      st_valid  [mem_emu_pkg::MEM_LAT_STAGES];
    mem_emu_pkg::tag_t         st_tag    [mem_emu_pkg::MEM_LAT_STAGES];
    mem_emu_pkg::data_t        st_value  [mem_emu_pkg::MEM_LAT_STAGES];
    logic                      st_except [mem_emu_pkg::MEM_LAT_STAGES];
    mem_emu_pkg::except_code_t st_code   [mem_emu_pkg::MEM_LAT_STAGES];

    // Skid spare entry, feeds the output entry
    logic                      sp_valid;
    mem_emu_pkg::tag_t         sp_tag;
    mem_emu_pkg::data_t        sp_value;
    logic                      sp_except;
    mem_emu_pkg::except_code_t sp_code;
    logic                      sp_move;

    // Spare moves on when the output entry is free or being taken
    assign sp_move = sp_valid && (!valid_o || ready_i);
    assign ready_o = (!sp_valid || sp_move) && !flush_i;

    // --------------------------------------------------
    // Latency stages
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin : p_stage_valid
        if (!rst_n_i || flush_i) begin
            for (int i = 0; i < mem_emu_pkg::MEM_LAT_STAGES; i++) begin
                st_valid[i] <= 1'b0;
            end
        end else if (ready_o) begin
            st_valid[0] <= valid_i;
            for (int i = 1; i < mem_emu_pkg::MEM_LAT_STAGES; i++) begin
                st_valid[i] <= st_valid[i-1];
            end
        end
    end

    always_ff @(posedge clk_i) begin : p_stage_data
        if (ready_o) begin
            st_tag[0]    <= tag_i;
            st_value[0]  <= value_i;
            st_except[0] <= except_i;
            st_code[0]   <= code_i;
            for (int i = 1; i < mem_emu_pkg::MEM_LAT_STAGES; i++) begin
                st_tag[i]    <= st_tag[i-1];
                st_value[i]  <= st_value[i-1];
                st_except[i] <= st_except[i-1];
                st_code[i]   <= st_code[i-1];
            end
        end
    end

    // --------------------------------------------------
    // Skid register
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin : p_skid_valid
        if (!rst_n_i || flush_i) begin
            sp_valid <= 1'b0;
            valid_o  <= 1'b0;
        end else begin
            if (ready_o) begin
                sp_valid <= st_valid[mem_emu_pkg::MEM_LAT_STAGES-1];
            end
            if (sp_move) begin
                valid_o <= 1'b1;
            end else if (ready_i) begin
                valid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin : p_skid_data
        if (ready_o) begin
            sp_tag    <= st_tag[mem_emu_pkg::MEM_LAT_STAGES-1];
            sp_value  <= st_value[mem_emu_pkg::MEM_LAT_STAGES-1];
            sp_except <= st_except[mem_emu_pkg::MEM_LAT_STAGES-1];
            sp_code   <= st_code[mem_emu_pkg::MEM_LAT_STAGES-1];
        end
        if (sp_move) begin
            tag_o    <= sp_tag;
            value_o  <= sp_value;
            except_o <= sp_except;
            code_o   <= sp_code;
        end
    end

    // A stalled answer holds until it is taken
    property p_ans_hold;
        @(posedge clk_i) disable iff (!rst_n_i)
            valid_o && !ready_i && !flush_i |=>
                valid_o && $stable(tag_o) && $stable(value_o)
                && $stable(except_o) && $stable(code_o);
    endproperty

    a_ans_hold : assert property (p_ans_hold)
        else $error("answer changed while stalled");

endmodule

// File: design/mem_emu_top.sv
// Memory emulator top: one instruction port, one data port
// Both ports share one array; answers come back through fixed latency
module mem_emu_top (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      flush_i,

    // Instruction request
    input  logic                      ins_valid_i,
    output logic                      ins_ready_o,
    input  mem_emu_pkg::tag_t         ins_tag_i,
    input  mem_emu_pkg::addr_t        ins_addr_i,
    // Instruction answer
    output logic                      ins_valid_o,
    input  logic                      ins_ready_i,
    output mem_emu_pkg::tag_t         ins_tag_o,
    output mem_emu_pkg::data_t        ins_value_o,
    output logic                      ins_except_o,
    output mem_emu_pkg::except_code_t ins_code_o,

    // Data request
    input  logic                      data_valid_i,
    output logic                      data_ready_o,
    input  mem_emu_pkg::tag_t         data_tag_i,
    input  mem_emu_pkg::addr_t        data_addr_i,
    input  logic                      data_store_i,
    input  mem_emu_pkg::size_t        data_size_i,
    input  mem_emu_pkg::data_t        data_wdata_i,
    // Data answer
    output logic                      data_valid_o,
    input  logic                      data_ready_i,
    output mem_emu_pkg::tag_t         data_tag_o,
    output mem_emu_pkg::data_t        data_value_o,
    output logic                      data_except_o,
    output mem_emu_pkg::except_code_t data_code_o
);

    logic                      ins_except;
    mem_emu_pkg::except_code_t ins_code;
    logic                      data_except;
    mem_emu_pkg::except_code_t data_code;
    mem_emu_pkg::be_t          data_be;
    mem_emu_pkg::data_t        ins_rdata;
    mem_emu_pkg::data_t        data_rdata;

    // --------------------------------------------------
    // Decode and execute
    // --------------------------------------------------
    mem_req_decoder u_decode (
        .ins_addr_i    (ins_addr_i),
        .data_addr_i   (data_addr_i),
        .data_store_i  (data_store_i),
        .data_size_i   (data_size_i),
        .ins_except_o  (ins_except),
        .ins_code_o    (ins_code),
        .data_except_o (data_except),
        .data_code_o   (data_code),
        .data_be_o     (data_be)
    );

    // Store is written only when the data pipe accepts it
    mem_array u_execute (
        .clk_i        (clk_i),
        .ins_addr_i   (ins_addr_i),
        .data_valid_i (data_valid_i),
        .data_ready_i (data_ready_o),
        .data_addr_i  (data_addr_i),
        .data_store_i (data_store_i),
        .data_size_i  (data_size_i),
        .data_wdata_i (data_wdata_i),
        .data_be_i    (data_be),
        .ins_rdata_o  (ins_rdata),
        .data_rdata_o (data_rdata)
    );

    // --------------------------------------------------
    // Answer pipes
    // --------------------------------------------------
    mem_ans_pipe u_ins_result (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .flush_i  (flush_i),
        .valid_i  (ins_valid_i),
        .ready_i  (ins_ready_i),
        .tag_i    (ins_tag_i),
        .value_i  (ins_rdata),
        .except_i (ins_except),
        .code_i   (ins_code),
        .valid_o  (ins_valid_o),
        .ready_o  (ins_ready_o),
        .tag_o    (ins_tag_o),
        .value_o  (ins_value_o),
        .except_o (ins_except_o),
        .code_o   (ins_code_o)
    );

    mem_ans_pipe u_data_result (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .flush_i  (flush_i),
        .valid_i  (data_valid_i),
        .ready_i  (data_ready_i),
        .tag_i    (data_tag_i),
        .value_i  (data_rdata),
        .except_i (data_except),
        .code_i   (data_code),
        .valid_o  (data_valid_o),
        .ready_o  (data_ready_o),
        .tag_o    (data_tag_o),
        .value_o  (data_value_o),
        .except_o (data_except_o),
        .code_o   (data_code_o)
    );

endmodule

// File: verification/mem_emu_tests.svh
// Directed tests, included inside the testbench module
// Each task leaves both request valids low and all answers drained
`ifndef MEM_EMU_TESTS_SVH
`define MEM_EMU_TESTS_SVH

// Reset state, then the answer delay of a single load
task automatic test_reset_latency();
    if (ins_valid_o !== 1'b0 || data_valid_o !== 1'b0) begin
        $display("An answer valid is high right after reset");
        fail_cnt++;
    end
    if (ins_ready_o !== 1'b1 || data_ready_o !== 1'b1) begin
        $display("A request ready is low right after reset");
        fail_cnt++;
    end
    send_data(1'b1, mem_emu_pkg::SZ_DOUBLE, '0, 64'h0123_4567_89ab_cdef);
    idle_ports();
    wait_drain();
    send_data(1'b0, mem_emu_pkg::SZ_DOUBLE, '0, '0);
    // Falling edge k follows the k-th rising edge after acceptance
    for (int k = 0; k <= LAT + 1; k++) begin
        @(negedge clk_i);
        data_valid_i = 1'b0;
        if (data_valid_o !== (k == LAT + 1)) begin
            $display("Load answer valid is %b %0d cycles after acceptance", data_valid_o, k);
            fail_cnt++;
        end
    end
    wait_drain();
endtask

// Fill the whole array, then random stores and loads of every size
task automatic test_random_access();
    mem_emu_pkg::size_t size;
    for (int i = 0; i < N_FILL; i++) begin
        send_data(1'b1, mem_emu_pkg::SZ_DOUBLE, mem_emu_pkg::addr_t'(i * 8), rand_bits(64));
    end
    for (int i = 0; i < N_RAND; i++) begin
        size = mem_emu_pkg::size_t'(rand_bits(2));
        send_data(1'b1, size, rand_addr(size), rand_bits(64));
    end
    for (int i = 0; i < N_RAND; i++) begin
        size = mem_emu_pkg::size_t'(rand_bits(2));
        send_data(1'b0, size, rand_addr(size), '0);
    end
    idle_ports();
    wait_drain();
endtask

// Words written on the data port come back on the instruction port
task automatic test_fetch();
    mem_emu_pkg::addr_t addrs [N_FETCH];
    for (int i = 0; i < N_FETCH; i++) begin
        addrs[i] = rand_addr(mem_emu_pkg::SZ_WORD);
        send_data(1'b1, mem_emu_pkg::SZ_WORD, addrs[i], rand_bits(64));
    end
    for (int i = 0; i < N_FETCH; i++) begin
        send_ins(addrs[i]);
    end
    idle_ports();
    wait_drain();
endtask

task automatic test_exceptions();
    mem_emu_pkg::addr_t top;
    top = mem_emu_pkg::addr_t'(mem_emu_pkg::MEM_BYTES);
    send_data(1'b0, mem_emu_pkg::SZ_HALF, 32'h101, '0);
    send_data(1'b1, mem_emu_pkg::SZ_WORD, 32'h102, 64'hdead_beef_dead_beef);
    send_data(1'b0, mem_emu_pkg::SZ_DOUBLE, top, '0);
    send_data(1'b1, mem_emu_pkg::SZ_BYTE, top + 32'd5, 64'h5a);
    // Misaligned and out of range together
    send_data(1'b0, mem_emu_pkg::SZ_WORD, top + 32'd2, '0);
    send_data(1'b1, mem_emu_pkg::SZ_DOUBLE, top + 32'd4, 64'h1);
    send_ins(32'h102);
    send_ins(top);
    send_ins(top + 32'd1);
    // Faulting stores must have left these dwords alone
    send_data(1'b0, mem_emu_pkg::SZ_DOUBLE, 32'h100, '0);
    send_data(1'b0, mem_emu_pkg::SZ_DOUBLE, 32'h000, '0);
    idle_ports();
    wait_drain();
endtask

// Stall the data answers until the request side stops
task automatic test_backpressure();
    int   n_acc;
    logic stalled;
    n_acc   = 0;
    stalled = 1'b0;
    while (!stalled && n_acc < 8) begin
        @(negedge clk_i);
        data_ready_i = 1'b0;
        drive_data(1'b0, mem_emu_pkg::SZ_DOUBLE, rand_addr(mem_emu_pkg::SZ_DOUBLE), '0);
        @(posedge clk_i);
        if (data_ready_o) begin
            record_data();
            n_acc++;
        end else begin
            stalled = 1'b1;
        end
    end
    @(negedge clk_i);
    data_valid_i = 1'b0;
    if (n_acc != LAT + 2) begin
        $display("Port took %0d requests under back-pressure instead of %0d", n_acc, LAT + 2);
        fail_cnt++;
    end
    data_ready_i = 1'b1;
    wait_drain();
endtask

task automatic test_flush();
    mem_emu_pkg::addr_t a;
    mem_emu_pkg::addr_t b;
    a = rand_addr(mem_emu_pkg::SZ_DOUBLE);
    b = (a + 32'd8) % mem_emu_pkg::addr_t'(mem_emu_pkg::MEM_BYTES);
    send_data(1'b1, mem_emu_pkg::SZ_DOUBLE, a, rand_bits(64));
    send_data(1'b0, mem_emu_pkg::SZ_DOUBLE, b, '0);
    send_ins(a);
    // Store presented with flush is dropped
    @(negedge clk_i);
    flush_i = 1'b1;
    drive_data(1'b1, mem_emu_pkg::SZ_DOUBLE, b, 64'hffff_0000_ffff_0000);
    @(posedge clk_i);
    ins_exp_q.delete();
    data_exp_q.delete();
    @(negedge clk_i);
    flush_i      = 1'b0;
    data_valid_i = 1'b0;
    @(negedge clk_i);
    if (ins_ready_o !== 1'b1 || data_ready_o !== 1'b1) begin
        $display("A request ready stayed low after flush");
        fail_cnt++;
    end
    repeat (LAT + 2) @(negedge clk_i);
    send_data(1'b0, mem_emu_pkg::SZ_DOUBLE, a, '0);
    send_data(1'b0, mem_emu_pkg::SZ_DOUBLE, b, '0);
    idle_ports();
    wait_drain();
endtask

`endif

// File: verification/mem_emu_tb.sv
// Testbench for mem_emu_top; inputs change on the falling clock edge
// The array has no reset contents, so every address is written before it is read
// Expected answers come from a byte shadow of the array and the decode rules
module mem_emu_tb;

    localparam int LAT       = mem_emu_pkg::MEM_LAT_STAGES;
    localparam int ADDR_BITS = $clog2(mem_emu_pkg::MEM_BYTES);
    localparam int N_FILL    = mem_emu_pkg::MEM_DWORDS;
    localparam int N_RAND    = 48;
    localparam int N_FETCH   = 16;
    localparam int N_OTHER   = 48;
    localparam int N_REQ     = N_FILL + 2 * N_RAND + 2 * N_FETCH + N_OTHER;
    localparam int CYC_LIMIT = N_REQ * (LAT + 3) + 500;

    logic                      clk_i;
    logic                      rst_n_i;
    logic                      flush_i;
    logic                      ins_valid_i;
    logic                      ins_ready_o;
    mem_emu_pkg::tag_t         ins_tag_i;
    mem_emu_pkg::addr_t        ins_addr_i;
    logic                      ins_valid_o;
    logic                      ins_ready_i;
    mem_emu_pkg::tag_t         ins_tag_o;
    mem_emu_pkg::data_t        ins_value_o;
    logic                      ins_except_o;
    mem_emu_pkg::except_code_t ins_code_o;
    logic                      data_valid_i;
    logic                      data_ready_o;
    mem_emu_pkg::tag_t         data_tag_i;
    mem_emu_pkg::addr_t        data_addr_i;
    logic                      data_store_i;
    mem_emu_pkg::size_t        data_size_i;
    mem_emu_pkg::data_t        data_wdata_i;
    logic                      data_valid_o;
    logic                      data_ready_i;
    mem_emu_pkg::tag_t         data_tag_o;
    mem_emu_pkg::data_t        data_value_o;
    logic                      data_except_o;
    mem_emu_pkg::except_code_t data_code_o;

    // Expected answer: {check value, except, code, tag, value}
    logic [73:0]       ins_exp_q[$];
    logic [73:0]       data_exp_q[$];
    logic [7:0]        shadow [mem_emu_pkg::MEM_BYTES];
    logic [31:0]       lfsr = 32'h218e_8c22;
    mem_emu_pkg::tag_t next_tag;
    int                err_cnt;
    int                fail_cnt;
    int                cyc;

    mem_emu_top dut_i (.*);

    initial begin : p_clk
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // --------------------------------------------------
    // Random numbers and reference rules
    // --------------------------------------------------
    function automatic mem_emu_pkg::data_t rand_bits(int n);
        mem_emu_pkg::data_t r;
        logic               fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[62:0], fb};
        end
        return r;
    endfunction

    // Random in-range address, naturally aligned for the size
    function automatic mem_emu_pkg::addr_t rand_addr(mem_emu_pkg::size_t size);
        mem_emu_pkg::addr_t a;
        a = mem_emu_pkg::addr_t'(rand_bits(ADDR_BITS));
        return a & ~mem_emu_pkg::addr_t'((32'd1 << size) - 32'd1);
    endfunction

    // Returns {except, code}; misalignment before range
    function automatic logic [4:0] data_rule(mem_emu_pkg::addr_t addr,
                                             mem_emu_pkg::size_t size, logic store);
        mem_emu_pkg::addr_t low_mask;
        low_mask = mem_emu_pkg::addr_t'((32'd1 << size) - 32'd1);
        if ((addr & low_mask) != '0) begin
            return {1'b1, store ? 4'd6 : 4'd4};
        end
        if (addr >= mem_emu_pkg::addr_t'(mem_emu_pkg::MEM_BYTES)) begin
            return {1'b1, store ? 4'd7 : 4'd5};
        end
        return {1'b0, 4'd15};
    endfunction

    function automatic logic [4:0] fetch_rule(mem_emu_pkg::addr_t addr);
        if (addr[1:0] != 2'b00) begin
            return {1'b1, 4'd0};
        end
        if (addr >= mem_emu_pkg::addr_t'(mem_emu_pkg::MEM_BYTES)) begin
            return {1'b1, 4'd1};
        end
        return {1'b0, 4'd15};
    endfunction

    // --------------------------------------------------
    // Compare tasks
    // --------------------------------------------------
    task automatic check_data(string what, mem_emu_pkg::data_t got, mem_emu_pkg::data_t exp);
        if (got !== exp) begin
            $display("Error at %0t: %s value %h, expected %h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_code(string what, logic got_exc, mem_emu_pkg::except_code_t got,
                              logic exp_exc, mem_emu_pkg::except_code_t exp);
        if (got_exc !== exp_exc || got !== exp) begin
            $display("Error at %0t: %s exception %b code %0d, expected %b code %0d",
                     $time, what, got_exc, got, exp_exc, exp);
            err_cnt++;
        end
    endtask

    task automatic check_tag(string what, mem_emu_pkg::tag_t got, mem_emu_pkg::tag_t exp);
        if (got !== exp) begin
            $display("Error at %0t: %s tag %h, expected %h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic compare_answer(string what, logic [73:0] e, mem_emu_pkg::tag_t tag,
                                  mem_emu_pkg::data_t value, logic exc,
                                  mem_emu_pkg::except_code_t code);
        check_tag(what, tag, e[67:64]);
        check_code(what, exc, code, e[72], e[71:68]);
        if (e[73]) begin
            check_data(what, value, e[63:0]);
        end
    endtask

    // --------------------------------------------------
    // Answer collectors and watchdog
    // --------------------------------------------------
    always @(posedge clk_i) begin : p_ins_collect
        logic [73:0] e;
        if (rst_n_i && ins_valid_o && ins_ready_i) begin
            if (ins_exp_q.size() == 0) begin
                $display("Instruction answer at %0t with no request outstanding", $time);
                fail_cnt++;
            end else begin
                e = ins_exp_q.pop_front();
                compare_answer("fetch", e, ins_tag_o, ins_value_o, ins_except_o, ins_code_o);
            end
        end
    end

    always @(posedge clk_i) begin : p_data_collect
        logic [73:0] e;
        if (rst_n_i && data_valid_o && data_ready_i) begin
            if (data_exp_q.size() == 0) begin
                $display("Data answer at %0t with no request outstanding", $time);
                fail_cnt++;
            end else begin
                e = data_exp_q.pop_front();
                compare_answer("data", e, data_tag_o, data_value_o, data_except_o,
                               data_code_o);
            end
        end
    end

    always @(posedge clk_i) begin : p_watchdog
        cyc++;
        if (cyc > CYC_LIMIT) begin
            $display("Timeout after %0d cycles, answers still missing", cyc);
            $display("TEST FAIL");
            $finish;
        end
    end

    // --------------------------------------------------
    // Request drivers
    // --------------------------------------------------
    task automatic drive_data(logic store, mem_emu_pkg::size_t size,
                              mem_emu_pkg::addr_t addr, mem_emu_pkg::data_t wdata);
        ins_valid_i  = 1'b0;
        data_valid_i = 1'b1;
        data_tag_i   = next_tag;
        data_store_i = store;
        data_size_i  = size;
        data_addr_i  = addr;
        data_wdata_i = wdata;
    endtask

    // Called on the accepting edge; updates the shadow for a good store
    task automatic record_data();
        logic [4:0]         rule;
        mem_emu_pkg::data_t val;
        rule = data_rule(data_addr_i, data_size_i, data_store_i);
        val  = '0;
        if (!rule[4]) begin
            for (int b = 0; b < (1 << data_size_i); b++) begin
                if (data_store_i) begin
                    shadow[data_addr_i + mem_emu_pkg::addr_t'(b)] = data_wdata_i[b*8 +: 8];
                end else begin
                    val[b*8 +: 8] = shadow[data_addr_i + mem_emu_pkg::addr_t'(b)];
                end
            end
        end
        data_exp_q.push_back({data_store_i || !rule[4], rule, data_tag_i, val});
        next_tag++;
    endtask

    task automatic send_data(logic store, mem_emu_pkg::size_t size,
                             mem_emu_pkg::addr_t addr, mem_emu_pkg::data_t wdata);
        @(negedge clk_i);
        drive_data(store, size, addr, wdata);
        @(posedge clk_i);
        while (!data_ready_o) @(posedge clk_i);
        record_data();
    endtask

    task automatic send_ins(mem_emu_pkg::addr_t addr);
        logic [4:0]         rule;
        mem_emu_pkg::data_t val;
        @(negedge clk_i);
        data_valid_i = 1'b0;
        ins_valid_i  = 1'b1;
        ins_tag_i    = next_tag;
        ins_addr_i   = addr;
        @(posedge clk_i);
        while (!ins_ready_o) @(posedge clk_i);
        rule = fetch_rule(addr);
        val  = '0;
        if (!rule[4]) begin
            for (int b = 0; b < 4; b++) begin
                val[b*8 +: 8] = shadow[addr + mem_emu_pkg::addr_t'(b)];
            end
        end
        ins_exp_q.push_back({!rule[4], rule, ins_tag_i, val});
        next_tag++;
    endtask

    task automatic idle_ports();
        @(negedge clk_i);
        ins_valid_i  = 1'b0;
        data_valid_i = 1'b0;
    endtask

    task automatic wait_drain();
        while (ins_exp_q.size() != 0 || data_exp_q.size() != 0) @(posedge clk_i);
        @(negedge clk_i);
    endtask

    `include "mem_emu_tests.svh"

    initial begin : p_main
        rst_n_i      = 1'b0;
        flush_i      = 1'b0;
        ins_valid_i  = 1'b0;
        ins_tag_i    = '0;
        ins_addr_i   = '0;
        ins_ready_i  = 1'b1;
        data_valid_i = 1'b0;
        data_tag_i   = '0;
        data_addr_i  = '0;
        data_store_i = 1'b0;
        data_size_i  = '0;
        data_wdata_i = '0;
        data_ready_i = 1'b1;
        next_tag     = '0;
        err_cnt      = 0;
        fail_cnt     = 0;
        cyc          = 0;
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        test_reset_latency();
        test_random_access();
        test_fetch();
        test_exceptions();
        test_backpressure();
        test_flush();
        idle_ports();
        wait_drain();
        $display("Run done: %0d value errors, %0d other errors", err_cnt, fail_cnt);
        if (err_cnt == 0 && fail_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+verification
design/mem_emu_pkg.sv
design/mem_req_decoder.sv
design/mem_array.sv
design/mem_ans_pipe.sv
design/mem_emu_top.sv
verification/mem_emu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the memory emulator testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f project.f --top-module mem_emu_tb -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAIL" sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi
if ! grep -q "TEST PASS" sim.log; then
    echo "Simulation ended without a result, see sim.log"
    exit 1
fi
echo "Simulation passed"
